// ==== Bender.yml ====
package:
  name: int_divider

sources:
  - files:
      - hdl/divPkg.sv
      - hdl/leadingZeroCount.sv
      - hdl/divPreproc.sv
      - hdl/divIterate.sv
      - hdl/divPostproc.sv
      - hdl/intDivider.sv
  - target: test
    files:
      - test/divChecker.sv
      - test/intDivider_assertions.sv
      - test/intDividerTb.sv

// ==== hdl/divIterate.sv ====
// Restoring division iterator
`timescale 1ns/1ns
`default_nettype none

module divIterate import divPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            operandsReady,  // Load strobe from decode
  input  logic            specialCase,    // Skip iteration
  input  logic [XLEN-1:0] dividendNorm,
  input  logic [XLEN-1:0] divisorAligned,
  input  logic [CNTW-1:0] iterCount,
  output logic            busy,
  output logic            iterDone,       // One-cycle strobe in stDone
  output logic [XLEN-1:0] quotientMag,
  output logic [XLEN-1:0] remainderMag
);

  iterState_t      state;
  logic [CNTW-1:0] counter;   // Quotient bits still to develop
  logic [XLEN-1:0] partRem;   // Partial remainder
  logic [XLEN-1:0] divisor;   // Shifts right each step
  logic [XLEN-1:0] quot;
  logic [XLEN:0]   trialDiff; // Extra bit carries the borrow
  logic            qBit;
  logic            load;

  assign load = operandsReady & (state == stIdle);

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= stIdle;
      counter <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (load) begin
            counter <= iterCount;
            state   <= specialCase ? stDone : stIterate; // Early exit
          end
        end
        stIterate: begin
          counter <= counter - CNTW'(1);
          if (counter == CNTW'(1)) begin
            state <= stDone;                             // Last bit this cycle
          end
        end
        stDone:  state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Restoring step: keep the difference only when it is not negative
  assign trialDiff = {1'b0, partRem} - {1'b0, divisor};
  assign qBit      = ~trialDiff[XLEN];

  always_ff @(posedge clk) begin
    if (load) begin
      partRem <= dividendNorm;        // Remainder for the special case too
      divisor <= divisorAligned;
      quot    <= '0;
    end else if (state == stIterate) begin
      if (qBit) begin
        partRem <= trialDiff[XLEN-1:0];
      end
      divisor <= divisor >> 1;
      quot    <= {quot[XLEN-2:0], qBit}; // New bit in at the bottom
    end
  end

  assign busy         = operandsReady | (state != stIdle);
  assign iterDone     = (state == stDone);
  assign quotientMag  = quot;
  assign remainderMag = partRem;

endmodule : divIterate

`default_nettype wire

// ==== hdl/divPkg.sv ====
// Integer divider shared definitions
`default_nettype none

package divPkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Operand and result width of the core
  localparam int XLEN = 32;

  // Iteration counter and leading-zero count width
  // Must hold 0 to XLEN inclusive
  localparam int CNTW = 6;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  // Bit 0 set means unsigned, bit 1 set means remainder
  typedef enum logic [1:0] {
    opDiv  = 2'b00, // Signed quotient
    opDivu = 2'b01, // Unsigned quotient
    opRem  = 2'b10, // Signed remainder
    opRemu = 2'b11  // Unsigned remainder
  } divOp_t;

  //////////////////////////////////////////////////
  // Execute FSM states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    stIdle    = 2'b00, // Waiting for operands
    stIterate = 2'b01, // One quotient bit per cycle
    stDone    = 2'b10  // Quotient and remainder valid for one cycle
  } iterState_t;

endpackage : divPkg

`default_nettype wire

// ==== hdl/divPostproc.sv ====
// Divider result stage
`timescale 1ns/1ns
`default_nettype none

module divPostproc import divPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            iterDone,     // Magnitudes valid this cycle
  input  logic            divByZero,
  input  logic            quotNeg,
  input  logic            remNeg,
  input  logic            remOp,        // Select remainder over quotient
  input  logic [XLEN-1:0] quotientMag,
  input  logic [XLEN-1:0] remainderMag,
  input  logic [XLEN-1:0] srcAHeld,     // Original dividend
  output logic            resultValid,
  output logic [XLEN-1:0] result
);

  logic [XLEN-1:0] quotSigned, remSigned;
  logic [XLEN-1:0] quotFinal, remFinal;
  logic [XLEN-1:0] resultE;            // Selected value before the register

  //////////////////////////////////////////////////
  // Sign correction
  //////////////////////////////////////////////////

  assign quotSigned = quotNeg ? -quotientMag : quotientMag;
  assign remSigned  = remNeg ? -remainderMag : remainderMag; // Remainder takes dividend sign

  // RISC-V divide by zero: all ones, dividend back as remainder
  assign quotFinal = divByZero ? '1 : quotSigned;
  assign remFinal  = divByZero ? srcAHeld : remSigned;

  // Overflow case needs no extra logic
  // -2^(XLEN-1) / -1 gives magnitude 2^(XLEN-1), not negated
  assign resultE = remOp ? remFinal : quotFinal;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= iterDone; // One cycle after iterDone
    end
  end

  // Holds until the next result
  always_ff @(posedge clk) begin
    if (iterDone) begin
      result <= resultE;
    end
  end

endmodule : divPostproc

`default_nettype wire

// ==== hdl/divPreproc.sv ====
// Divider decode stage
`timescale 1ns/1ns
`default_nettype none

module divPreproc import divPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,          // Operand strobe from the core
  input  logic            busy,           // Execute stage occupied
  input  divOp_t          op,
  input  logic [XLEN-1:0] srcA,           // Dividend
  input  logic [XLEN-1:0] srcB,           // Divisor
  output logic            operandsReady,  // Registered accept strobe
  output logic [XLEN-1:0] dividendNorm,   // Dividend magnitude
  output logic [XLEN-1:0] divisorAligned, // Divisor under the dividend's leading one
  output logic [XLEN-1:0] srcAHeld,       // Original dividend
  output logic [CNTW-1:0] iterCount,      // Quotient bits to develop
  output logic            specialCase,    // Finish without iterating
  output logic            divByZero,
  output logic            quotNeg,
  output logic            remNeg,
  output logic            remOp
);

  logic            accept;       // Start taken this cycle
  logic            signedOp;
  logic            remSel;
  logic            aSign, bSign; // Operand signs forced low for unsigned ops
  logic            bZero;
  logic            aLtB;         // Dividend has more leading zeros
  logic            special;
  logic [XLEN-1:0] posA, posB;   // Operand magnitudes
  logic [CNTW-1:0] ell, mE;      // Leading zeros of posA and posB
  logic [CNTW-1:0] zeroDiff;
  logic [CNTW-1:0] bitsE;        // Iteration count before the register
  logic [XLEN-1:0] divAlignE;

  assign accept = start & ~busy; // One op in flight at most

  //////////////////////////////////////////////////
  // Sign handling
  //////////////////////////////////////////////////

  assign signedOp = ~op[0];
  assign remSel   = op[1];

  assign aSign = srcA[XLEN-1] & signedOp;
  assign bSign = srcB[XLEN-1] & signedOp;
  assign bZero = ~(|srcB);

  // Most negative number keeps 2^(XLEN-1) as its unsigned magnitude
  assign posA = aSign ? -srcA : srcA;
  assign posB = bSign ? -srcB : srcB;

  //////////////////////////////////////////////////
  // Normalization and special cases
  //////////////////////////////////////////////////

  leadingZeroCount lzcA (.word(posA), .count(ell));
  leadingZeroCount lzcB (.word(posB), .count(mE));

  assign zeroDiff = mE - ell;         // Negative when a < b in magnitude
  assign aLtB     = zeroDiff[CNTW-1]; // Sign bit of the difference
  assign special  = bZero | aLtB;

  // No digit-boundary shift at radix 2
  assign divAlignE = special ? posB : (posB << zeroDiff);
  assign bitsE     = special ? '0 : (zeroDiff + CNTW'(1));

  //////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      operandsReady <= 1'b0;
    end else begin
      operandsReady <= accept;
    end
  end

  // Held until the next accepted start
  always_ff @(posedge clk) begin
    if (accept) begin
      dividendNorm   <= posA;
      divisorAligned <= divAlignE;
      srcAHeld       <= srcA;
      iterCount      <= bitsE;
      specialCase    <= special;
      divByZero      <= bZero;
      quotNeg        <= (aSign ^ bSign) & ~bZero; // Signed op implied by the sign bits
      remNeg         <= aSign;
      remOp          <= remSel;
    end
  end

endmodule : divPreproc

`default_nettype wire

// ==== hdl/intDivider.sv ====
// Integer divide and remainder unit
`timescale 1ns/1ns
`default_nettype none

module intDivider import divPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,       // One-cycle operand strobe
  input  divOp_t          op,
  input  logic [XLEN-1:0] srcA,
  input  logic [XLEN-1:0] srcB,
  output logic            busy,        // New starts ignored while high
  output logic            resultValid,
  output logic [XLEN-1:0] result
);

  // Decode to execute
  logic            operandsReady;
  logic [XLEN-1:0] dividendNorm, divisorAligned;
  logic [CNTW-1:0] iterCount;
  logic            specialCase;

  // Decode to result
  logic [XLEN-1:0] srcAHeld;
  logic            divByZero, quotNeg, remNeg, remOp;

  // Execute to result
  logic            iterDone;
  logic [XLEN-1:0] quotientMag, remainderMag;

  divPreproc preproc (
    .clk, .reset, .start, .busy, .op, .srcA, .srcB,
    .operandsReady, .dividendNorm, .divisorAligned, .srcAHeld,
    .iterCount, .specialCase, .divByZero, .quotNeg, .remNeg, .remOp
  );

  divIterate iterate (
    .clk, .reset, .operandsReady, .specialCase,
    .dividendNorm, .divisorAligned, .iterCount,
    .busy, .iterDone, .quotientMag, .remainderMag
  );

  divPostproc postproc (
    .clk, .reset, .iterDone, .divByZero, .quotNeg, .remNeg, .remOp,
    .quotientMag, .remainderMag, .srcAHeld,
    .resultValid, .result
  );

endmodule : intDivider

`default_nettype wire

// ==== hdl/leadingZeroCount.sv ====
// Leading zero counter
`timescale 1ns/1ns
`default_nettype none

module leadingZeroCount import divPkg::*; (
  input  logic [XLEN-1:0] word,  // Word to scan
  output logic [CNTW-1:0] count  // Zeros above the leading one
);

  // Priority scan from the bottom up
  // The highest set bit writes last and wins
  always_comb begin
    count = CNTW'(XLEN);                   // All-zero word
    for (int i = 0; i < XLEN; i++) begin
      if (word[i]) begin
        count = CNTW'(XLEN - 1 - i);       // Zeros above bit i
      end
    end
  end

endmodule : leadingZeroCount

`default_nettype wire

// ==== sim.f ====
hdl/divPkg.sv
hdl/leadingZeroCount.sv
hdl/divPreproc.sv
hdl/divIterate.sv
hdl/divPostproc.sv
hdl/intDivider.sv
test/divChecker.sv
test/intDivider_assertions.sv
test/intDividerTb.sv

// ==== test/divChecker.sv ====
// Divider result checker
`timescale 1ns/1ns
`default_nettype none

module divChecker import divPkg::*; (
  input logic            clk,
  input logic            reset,
  input logic            start,
  input logic            busy,
  input divOp_t          op,
  input logic [XLEN-1:0] srcA,
  input logic [XLEN-1:0] srcB,
  input logic            resultValid,
  input logic [XLEN-1:0] result
);

  logic [XLEN-1:0] expValue[$];   // One entry per accepted start
  int              expLatency[$];
  int              startCycle[$];
  string           opText[$];     // Operands, for the error line
  logic [XLEN-1:0] expected;
  int              wantLatency, gotLatency;
  string           operands;
  int              cycle = 0;
  int              totalChecks = 0;
  int              totalErrors = 0;
  int              testChecks = 0;
  int              testErrors = 0;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int leadingZeros(input logic [XLEN-1:0] w);
    int n;
    n = 0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (w[i]) return n;
      n++;
    end
    return n;                     // All-zero word
  endfunction

  // RISC-V quotient or remainder built from magnitudes and signs
  function automatic logic [XLEN-1:0] refResult(input divOp_t fop,
                                                input logic [XLEN-1:0] a, b);
    logic            isSigned, negA, negB;
    logic [XLEN-1:0] magA, magB, qMag, rMag, q, r;
    isSigned = (fop == opDiv) || (fop == opRem);
    negA = isSigned & a[XLEN-1];
    negB = isSigned & b[XLEN-1];
    magA = negA ? -a : a;
    magB = negB ? -b : b;
    if (b == '0) begin
      q = '1;                     // Divide by zero
      r = a;
    end else begin
      qMag = magA / magB;
      rMag = magA % magB;
      q = (negA ^ negB) ? -qMag : qMag;
      r = negA ? -rMag : rMag;    // Remainder follows the dividend
    end
    return ((fop == opRem) || (fop == opRemu)) ? r : q;
  endfunction

  // Cycles from the start edge to the resultValid edge
  function automatic int refLatency(input divOp_t fop, input logic [XLEN-1:0] a, b);
    logic isSigned;
    int   lzA, lzB;
    isSigned = (fop == opDiv) || (fop == opRem);
    lzA = leadingZeros((isSigned & a[XLEN-1]) ? -a : a);
    lzB = leadingZeros((isSigned & b[XLEN-1]) ? -b : b);
    if ((b == '0) || (lzA > lzB)) return 3; // Early exit, N is zero
    return (lzB - lzA + 1) + 3;
  endfunction

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic flagError(input string msg);
    $display("%s", msg);
    totalErrors++;
    testErrors++;
  endtask

  task automatic reportTest(input string name);
    $display("Test %s: %0d results checked, %0d errors", name, testChecks, testErrors);
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic checkDrained();
    if (expValue.size() != 0) begin
      flagError($sformatf("%0d accepted operations never gave resultValid", expValue.size()));
    end
  endtask

  //////////////////////////////////////////////////
  // Compare on resultValid, record on accepted start
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle++;
    if (!reset) begin
      if (resultValid && (expValue.size() == 0)) begin
        flagError("resultValid pulsed with no operation outstanding");
      end else if (resultValid) begin
        expected    = expValue.pop_front();
        wantLatency = expLatency.pop_front();
        gotLatency  = cycle - startCycle.pop_front();
        operands    = opText.pop_front();
        totalChecks++;
        testChecks++;
        if (result !== expected) begin
          flagError($sformatf("ERR result: expected %h, got %h (%s)", expected, result, operands));
        end
        if (gotLatency != wantLatency) begin
          flagError($sformatf("Result came %0d cycles after start, not %0d (%s)",
                              gotLatency, wantLatency, operands));
        end
      end
      if (start && !busy) begin   // Only an accepted start gives a result
        expValue.push_back(refResult(op, srcA, srcB));
        expLatency.push_back(refLatency(op, srcA, srcB));
        startCycle.push_back(cycle);
        opText.push_back($sformatf("op %0d, srcA %h, srcB %h", op, srcA, srcB));
      end
    end
  end

endmodule : divChecker

`default_nettype wire

// ==== test/intDividerTb.sv ====
// Integer divider testbench
`timescale 1ns/1ns
`default_nettype none

module intDividerTb import divPkg::*; ();

  localparam int randomPerOp = 200;
  // Random, divide by zero, overflow, early exit, latency, overlap
  localparam int opCount     = 4 * randomPerOp + 12 + 12 + 16 + 8 + 2;
  localparam int cycleLimit  = opCount * 40 + 100;
  localparam logic [XLEN-1:0] minInt = {1'b1, {(XLEN-1){1'b0}}};

  logic            clk;
  logic            reset;
  logic            start;
  divOp_t          op;
  logic [XLEN-1:0] srcA, srcB;
  logic            busy, resultValid;
  logic [XLEN-1:0] result;
  int              cycleCount = 0;
  int              failTotal;

  divOp_t          allOps [4]        = '{opDiv, opDivu, opRem, opRemu};
  logic [XLEN-1:0] zeroDividends [3] = '{32'd5, 32'hFFFF_FFF9, 32'd0};

  intDivider intDivider_inst (
    .clk, .reset, .start, .op, .srcA, .srcB, .busy, .resultValid, .result
  );

  divChecker resultCheck (
    .clk, .reset, .start, .busy, .op, .srcA, .srcB, .resultValid, .result
  );

  always #5 clk = ~clk; // 10 ns period

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: no end of run within %0d cycles", cycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // One operation held until its result appears
  task automatic issueOp(input divOp_t o, input logic [XLEN-1:0] a, b);
    @(negedge clk);
    start = 1'b1;
    op    = o;
    srcA  = a;
    srcB  = b;
    @(negedge clk);
    start = 1'b0;
    while (!resultValid) @(negedge clk);
  endtask

  task automatic finishTest(input string name);
    @(negedge clk);            // Let the checker see the last result
    resultCheck.reportTest(name);
  endtask

  task automatic randomOps();
    logic [XLEN-1:0] a, b;
    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < randomPerOp; n++) begin
        a = $urandom;
        b = $urandom >> ($urandom % XLEN); // Spread the quotient length
        issueOp(allOps[k], a, b);
      end
    end
    finishTest("random");
  endtask

  task automatic cornerCases();
    for (int k = 0; k < 4; k++) begin
      for (int d = 0; d < 3; d++) begin
        issueOp(allOps[k], zeroDividends[d], '0);
      end
    end
    finishTest("divide by zero");
    for (int k = 0; k < 4; k++) begin
      issueOp(allOps[k], minInt, '1);     // Signed overflow
      issueOp(allOps[k], minInt, 32'd1);
      issueOp(allOps[k], minInt, minInt);
    end
    finishTest("overflow");
    for (int k = 0; k < 4; k++) begin
      issueOp(allOps[k], 32'd0, 32'd7);
      issueOp(allOps[k], 32'd3, 32'd9);
      issueOp(allOps[k], 32'hFFFF_FFFD, 32'd9);
      issueOp(allOps[k], 32'd5, 32'hFFFF_FFF0);
    end
    finishTest("early exit");
  endtask

  task automatic latencyCases();
    issueOp(opDivu, 32'hFFFF_FFFF, 32'd1); // Longest case with N of 32
    issueOp(opDiv, 32'd1, 32'd1);
    issueOp(opDiv, 32'd100, 32'd7);
    issueOp(opRem, 32'hFFFF_FF9C, 32'd7);
    issueOp(opDiv, 32'h7FFF_FFFF, 32'd2);
    issueOp(opRemu, 32'h1234_5678, 32'h10);
    issueOp(opDivu, minInt, minInt);
    issueOp(opDiv, 32'd1000, 32'hFFFF_FFFD);
    finishTest("latency");
  endtask

  // Second start lands mid-iteration
  task automatic startWhileBusy();
    @(negedge clk);
    start = 1'b1;
    op    = opDivu;
    srcA  = 32'hFFFF_FFFF;
    srcB  = 32'd3;
    @(negedge clk);
    start = 1'b0;
    repeat (3) @(negedge clk);
    if (!busy) resultCheck.flagError("busy was low while a division was running");
    start = 1'b1;
    op    = opRem;
    srcA  = 32'd77;
    srcB  = 32'd5;
    @(negedge clk);
    start = 1'b0;
    while (!resultValid) @(negedge clk);
    repeat (20) @(negedge clk);  // Any second resultValid is flagged
    finishTest("start while busy");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned seedInit;
    seedInit = $urandom(32'hb386_4c7f);
    clk   = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    op    = opDiv;
    srcA  = '0;
    srcB  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    randomOps();
    cornerCases();
    latencyCases();
    startWhileBusy();
    resultCheck.checkDrained();
    failTotal = resultCheck.totalErrors + intDivider_inst.assertionsInst.failCount;
    $display("Summary: %0d results checked, %0d check errors, %0d assertion failures",
             resultCheck.totalChecks, resultCheck.totalErrors,
             intDivider_inst.assertionsInst.failCount);
    if (failTotal == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : intDividerTb

`default_nettype wire

// ==== test/intDivider_assertions.sv ====
// Divider protocol assertions
`timescale 1ns/1ns
`default_nettype none

module intDividerAssertions (
  input logic clk,
  input logic reset,
  input logic busy,
  input logic resultValid
);

  int failCount = 0; // Assertion failures so far

  // Single-cycle result strobe
  validOneCycle: assert property (@(posedge clk) disable iff (reset)
    resultValid |=> !resultValid)
    else begin
      $error("resultValid stayed high for two cycles");
      failCount++;
    end

  // Unit frees up in the result cycle
  busyDropsWithValid: assert property (@(posedge clk) disable iff (reset)
    $rose(resultValid) |-> $fell(busy))
    else begin
      $error("busy did not fall as resultValid rose");
      failCount++;
    end

  quietAfterReset: assert property (@(posedge clk)
    $fell(reset) |-> (!busy && !resultValid))
    else begin
      $error("busy or resultValid high right after reset");
      failCount++;
    end

endmodule : intDividerAssertions

bind intDivider intDividerAssertions assertionsInst (
  .clk(clk), .reset(reset), .busy(busy), .resultValid(resultValid)
);

`default_nettype wire
